// ==== Makefile ====
# Verilator build and run of the peripheral block testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f files.f --top-module scc_tb -o scc_sim
	./obj_dir/scc_sim +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== files.f ====
+incdir+hw
hw/scc_pkg.sv
hw/scc_bus_decode.sv
hw/scc_uart_rx.sv
hw/scc_uart_tx.sv
hw/scc_uart.sv
hw/scc_timer.sv
hw/scc_irq_ctrl.sv
hw/scc_periph_top.sv
tb/scc_sva.sv
tb/scc_tb.sv

// ==== hw/scc_bus_decode.sv ====
/*
 * Peripheral address decoder.
 * Names the register hit by the word address and qualifies writes and reads.
 */

`include "scc_config.svh"

module scc_bus_decode (
    input  logic              periph_sel,
    input  logic [15:1]       addr,
    input  logic              uds,
    input  logic              lds,
    input  logic              write_strobe,
    output scc_pkg::reg_sel_t sel,
    output logic              wr_hi,
    output logic              wr_lo,
    output logic              rd_lo
);
    import scc_pkg::*;

    logic [14:0] uart_off;
    logic [14:0] timer_off;

    // Below the base wraps to a large offset, so one compare covers the range
    assign uart_off  = addr - `SCC_UART_BASE;
    assign timer_off = addr - `SCC_TIMER_BASE;

    always_comb begin
        sel = SEL_NONE;
        if (periph_sel) begin
            if (addr == `SCC_LIR_ADDR) begin
                sel = SEL_LIR;
            end else if (addr == `SCC_PICR1_ADDR) begin
                sel = SEL_PICR1;
            end else if (uart_off < 15'(`SCC_UART_WORDS)) begin
                case (uart_off[2:0])
                    3'd1:    sel = SEL_UART_STATUS;
                    3'd4:    sel = SEL_UART_THR;
                    3'd5:    sel = SEL_UART_RHR;
                    default: sel = SEL_UART_OTHER;  // Mode, clock select, command
                endcase
            end else if (timer_off < 15'(`SCC_TIMER_WORDS)) begin
                case (timer_off[2:0])
                    3'd0:    sel = SEL_TIMER_STATUS;
                    3'd1:    sel = SEL_TIMER_RELOAD;
                    3'd2:    sel = SEL_TIMER0;
                    default: sel = SEL_TIMER_OTHER;  // Timers 1 and 2
                endcase
            end
        end
    end

    assign wr_hi = periph_sel && uds && write_strobe;
    assign wr_lo = periph_sel && lds && write_strobe;
    assign rd_lo = periph_sel && lds && !write_strobe;

endmodule

// ==== hw/scc_config.svh ====
/*
 * Peripheral block configuration.
 * Word address map, UART bit time, timer 0 prescale and on-chip vector base.
 */

`ifndef SCC_CONFIG_SVH
`define SCC_CONFIG_SVH

// Word addresses, CPU address bits 15:1
`define SCC_LIR_ADDR           15'h0800
`define SCC_UART_BASE          15'h1008
`define SCC_UART_WORDS         6
`define SCC_TIMER_BASE         15'h1010
`define SCC_TIMER_WORDS        5
`define SCC_PICR1_ADDR         15'h1022

// 30 MHz system clock at 115200 baud
`define SCC_UART_CLKS_PER_BIT  260

// Clocks per timer 0 increment
`define SCC_TIMER_PRESCALE     192

// Vector number for level 0, level is added on top
`define SCC_VECTOR_BASE        56

`endif

// ==== hw/scc_irq_ctrl.sv ====
/*
 * Interrupt controller.
 * LIR and PICR1 timer level, priority selection, acknowledge decode
 * and the per-level autovector flag.
 */

module scc_irq_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  scc_pkg::reg_sel_t sel,
    input  logic              wr_lo,
    input  logic [7:0]        wdata,
    input  logic              int1,
    input  logic              int2,
    input  logic              in2,
    input  logic              in4,
    input  logic              in5,
    input  logic              av,
    input  logic              irq_ack,
    input  scc_pkg::ipl_t     ack_level,
    input  logic              t0_ov,
    output scc_pkg::lir_t     lir,
    output scc_pkg::ipl_t     timer_level,
    output scc_pkg::ipl_t     ipl,
    output logic              on_chip,
    output logic              autovector,
    output logic              iack2,
    output logic              iack4,
    output logic              iack5
);
    import scc_pkg::*;

    logic [7:0] av_table;  // One flag per level, set means autovectored

    always_ff @(posedge clk) begin
        if (reset) begin
            lir         <= '0;
            timer_level <= '0;
            autovector  <= 1'b0;
        end else begin
            if (sel == SEL_LIR && wr_lo) begin
                lir.int1_level <= wdata[6:4];
                lir.int2_level <= wdata[2:0];
            end
            if (sel == SEL_PICR1 && wr_lo) timer_level <= wdata[2:0];
            autovector <= av_table[ack_level];
        end
    end

    // Later sources override earlier ones
    always_comb begin
        ipl         = '0;
        on_chip     = 1'b0;
        av_table    = '1;
        av_table[4] = av;
        if (in2) ipl = 3'd2;
        if (in4) ipl = 3'd4;
        if (in5) ipl = 3'd5;
        if (int1 && lir.int1_level != 3'd0) begin
            ipl                      = lir.int1_level;
            av_table[lir.int1_level] = 1'b0;
            on_chip                  = 1'b1;
        end
        if (int2 && lir.int2_level != 3'd0) begin
            ipl                      = lir.int2_level;
            av_table[lir.int2_level] = 1'b0;
            on_chip                  = 1'b1;
        end
        if (t0_ov && timer_level != 3'd0) begin
            ipl                   = timer_level;
            av_table[timer_level] = 1'b0;  // Vector comes from the read mux
            on_chip               = 1'b1;
        end
    end

    assign iack2 = in2 && irq_ack && ack_level == 3'd2;
    assign iack4 = in4 && irq_ack && ack_level == 3'd4;
    assign iack5 = in5 && irq_ack && ack_level == 3'd5;

endmodule

// ==== hw/scc_periph_top.sv ====
/*
 * On-chip peripheral block, CPU bus side.
 * Joins decoder, UART, timer 0 and interrupt controller and muxes read data.
 */

`include "scc_config.svh"

module scc_periph_top (
    input  logic          clk,
    input  logic          reset,
    input  logic          periph_sel,
    input  logic [15:1]   addr,
    input  logic          uds,
    input  logic          lds,
    input  logic          write_strobe,
    input  logic [15:0]   wdata,
    output logic [15:0]   rdata,
    input  logic          int1,
    input  logic          int2,
    input  logic          in2,
    input  logic          in4,
    input  logic          in5,
    input  logic          av,
    input  logic          irq_ack,
    input  scc_pkg::ipl_t ack_level,
    output scc_pkg::ipl_t ipl,
    output logic          autovector,
    output logic          iack2,
    output logic          iack4,
    output logic          iack5,
    input  logic          uart_rx,
    output logic          uart_tx
);
    import scc_pkg::*;

    reg_sel_t     sel;
    logic         wr_hi, wr_lo, rd_lo;
    uart_status_t uart_status;
    logic [7:0]   uart_rhr;
    logic [15:0]  timer0, reload;
    logic         t0_ov;
    lir_t         lir;
    ipl_t         timer_level;
    logic         on_chip;

    scc_bus_decode u_bus_decode (
        .periph_sel (periph_sel), .addr (addr), .uds (uds), .lds (lds),
        .write_strobe (write_strobe), .sel (sel),
        .wr_hi (wr_hi), .wr_lo (wr_lo), .rd_lo (rd_lo)
    );

    scc_uart u_uart (
        .clk (clk), .reset (reset), .uart_rx (uart_rx), .sel (sel),
        .wr_lo (wr_lo), .rd_lo (rd_lo), .wdata (wdata[7:0]),
        .status (uart_status), .rhr (uart_rhr), .uart_tx (uart_tx)
    );

    scc_timer u_timer (
        .clk (clk), .reset (reset), .sel (sel), .wr_hi (wr_hi), .wr_lo (wr_lo),
        .wdata (wdata), .timer0 (timer0), .reload (reload), .t0_ov (t0_ov)
    );

    scc_irq_ctrl u_irq_ctrl (
        .clk (clk), .reset (reset), .sel (sel), .wr_lo (wr_lo), .wdata (wdata[7:0]),
        .int1 (int1), .int2 (int2), .in2 (in2), .in4 (in4), .in5 (in5), .av (av),
        .irq_ack (irq_ack), .ack_level (ack_level), .t0_ov (t0_ov),
        .lir (lir), .timer_level (timer_level), .ipl (ipl), .on_chip (on_chip),
        .autovector (autovector), .iack2 (iack2), .iack4 (iack4), .iack5 (iack5)
    );

    always_comb begin
        case (sel)
            SEL_LIR:          rdata = {lir, lir};  // Same byte on both lanes
            SEL_PICR1:        rdata = {2{5'b0, timer_level}};
            SEL_UART_STATUS:  rdata = {8'h00, uart_status};
            SEL_UART_RHR:     rdata = {8'h00, uart_rhr};
            SEL_TIMER_STATUS: rdata = {t0_ov, 15'b0};  // Control byte reads zero
            SEL_TIMER_RELOAD: rdata = reload;
            SEL_TIMER0:       rdata = timer0;
            default:          rdata = '0;
        endcase
        // Interrupt acknowledge cycle takes the on-chip vector
        if (irq_ack && on_chip) rdata = 16'(`SCC_VECTOR_BASE) + 16'(ack_level);
    end

endmodule

// ==== hw/scc_pkg.sv ====
/*
 * Peripheral block types.
 * Register select codes and the packed layouts of LIR and UART status.
 */

package scc_pkg;

    // Register hit by the current bus address
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_LIR,
        SEL_PICR1,
        SEL_UART_STATUS,
        SEL_UART_THR,
        SEL_UART_RHR,
        SEL_TIMER_STATUS,
        SEL_TIMER_RELOAD,
        SEL_TIMER0,
        SEL_TIMER_OTHER,
        SEL_UART_OTHER
    } reg_sel_t;

    typedef logic [2:0] ipl_t;  // 0 means no request

    typedef struct packed {
        logic rsvd1;
        ipl_t int1_level;
        logic rsvd2;
        ipl_t int2_level;
    } lir_t;

    typedef struct packed {
        logic [3:0] rsvd_hi;   // Break and error flags, not modelled
        logic       tx_emt;
        logic       tx_rdy;
        logic       rsvd1;
        logic       rx_rdy;
    } uart_status_t;

endpackage

// ==== hw/scc_timer.sv ====
/*
 * Timer 0.
 * Prescaled up counter with reload register and overflow flag.
 */

`include "scc_config.svh"

module scc_timer (
    input  logic              clk,
    input  logic              reset,
    input  scc_pkg::reg_sel_t sel,
    input  logic              wr_hi,
    input  logic              wr_lo,
    input  logic [15:0]       wdata,
    output logic [15:0]       timer0,
    output logic [15:0]       reload,
    output logic              t0_ov
);
    import scc_pkg::*;

    localparam int PRESCALE = `SCC_TIMER_PRESCALE;
    localparam int PS_W     = $clog2(PRESCALE);

    logic [PS_W-1:0] presc_q;
    logic            at_max;
    logic            t0_wr;

    assign at_max = (timer0 == 16'hffff);
    assign t0_wr  = (sel == SEL_TIMER0) && (wr_hi || wr_lo);

    always_ff @(posedge clk) begin
        if (reset) begin
            timer0  <= '0;
            presc_q <= '0;
        end else if (at_max) begin
            timer0  <= reload;
            presc_q <= '0;
        end else if (t0_wr) begin
            if (wr_hi) timer0[15:8] <= wdata[15:8];
            if (wr_lo) timer0[7:0]  <= wdata[7:0];
            presc_q <= '0;  // Restart the tick
        end else if (presc_q == PS_W'(PRESCALE - 1)) begin
            timer0  <= timer0 + 1'b1;
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reload <= '0;
            t0_ov  <= 1'b0;
        end else begin
            if (sel == SEL_TIMER_RELOAD && wr_hi) reload[15:8] <= wdata[15:8];
            if (sel == SEL_TIMER_RELOAD && wr_lo) reload[7:0]  <= wdata[7:0];
            if (at_max) begin
                t0_ov <= 1'b1;
            end else if (sel == SEL_TIMER_STATUS && wr_hi && wdata[15]) begin
                t0_ov <= 1'b0;  // Write one to clear
            end
        end
    end

endmodule

// ==== hw/scc_uart.sv ====
/*
 * UART register block.
 * Receive and transmit holding registers and the status byte.
 */

module scc_uart (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  uart_rx,
    input  scc_pkg::reg_sel_t     sel,
    input  logic                  wr_lo,
    input  logic                  rd_lo,
    input  logic [7:0]            wdata,
    output scc_pkg::uart_status_t status,
    output logic [7:0]            rhr,
    output logic                  uart_tx
);
    import scc_pkg::*;

    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rhr_valid_q;
    logic [7:0] thr_q;
    logic       thr_valid_q;
    logic       tx_ready;

    scc_uart_rx u_rx (
        .clk      (clk),
        .reset    (reset),
        .uart_rx  (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    scc_uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (thr_q),
        .tx_valid (thr_valid_q),
        .tx_ready (tx_ready),
        .uart_tx  (uart_tx)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rhr_valid_q <= 1'b0;
            thr_valid_q <= 1'b0;
        end else begin
            if (rx_valid) begin  // A new byte wins over a read
                rhr         <= rx_data;
                rhr_valid_q <= 1'b1;
            end else if (sel == SEL_UART_RHR && rd_lo) begin
                rhr_valid_q <= 1'b0;
            end

            if (sel == SEL_UART_THR && wr_lo) begin
                thr_q       <= wdata;
                thr_valid_q <= 1'b1;
            end else if (thr_valid_q && tx_ready) begin
                thr_valid_q <= 1'b0;  // Handed to the transmitter
            end
        end
    end

    always_comb begin
        status        = '0;
        status.rx_rdy = rhr_valid_q;
        status.tx_rdy = !thr_valid_q;
        status.tx_emt = tx_ready;
    end

endmodule

// ==== hw/scc_uart_rx.sv ====
/*
 * UART receiver, 8N1.
 * Samples each bit at its centre and presents the byte for one cycle.
 */

`include "scc_config.svh"

module scc_uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       uart_rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int CLKS  = `SCC_UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state_q;
    logic [1:0]       sync_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_q;
    logic [7:0]       shift_q;
    logic             line;

    assign line    = sync_q[1];
    assign rx_data = shift_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= RX_IDLE;
            sync_q   <= 2'b11;  // Line idles high
            cnt_q    <= '0;
            bit_q    <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], uart_rx};
            rx_valid <= 1'b0;
            cnt_q    <= cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!line) state_q <= RX_START;
                end
                RX_START: begin
                    // Still low at mid start bit, otherwise a glitch
                    if (cnt_q == CNT_W'(CLKS / 2 - 1)) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= line ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (cnt_q == CNT_W'(CLKS - 1)) begin
                        cnt_q   <= '0;
                        shift_q <= {line, shift_q[7:1]};  // LSB first
                        bit_q   <= bit_q + 1'b1;
                        if (bit_q == 3'd7) state_q <= RX_STOP;
                    end
                end
                default: begin
                    if (cnt_q == CNT_W'(CLKS - 1)) begin
                        rx_valid <= line;  // Framing error drops the byte
                        state_q  <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/scc_uart_tx.sv ====
/*
 * UART transmitter, 8N1.
 * Takes a byte when idle and shifts out start, eight data bits LSB first, stop.
 */

`include "scc_config.svh"

module scc_uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       uart_tx
);
    localparam int CLKS  = `SCC_UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [3:0]       bit_q;
    logic [9:0]       frame_q;  // Stop, data, start

    assign tx_ready = !busy_q;
    assign uart_tx  = busy_q ? frame_q[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            bit_q  <= '0;
        end else if (!busy_q) begin
            if (tx_valid) begin
                busy_q  <= 1'b1;
                frame_q <= {1'b1, tx_data, 1'b0};
                cnt_q   <= '0;
                bit_q   <= '0;
            end
        end else if (cnt_q == CNT_W'(CLKS - 1)) begin
            cnt_q   <= '0;
            frame_q <= {1'b1, frame_q[9:1]};
            // Ten bit times in total
            if (bit_q == 4'd9) begin
                busy_q <= 1'b0;
            end else begin
                bit_q <= bit_q + 1'b1;
            end
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

// ==== tb/scc_sva.sv ====
/*
 * Peripheral block assertions, bound into the top level.
 * Reset state, acknowledge decode and timer reload.
 */

`include "scc_config.svh"

module scc_sva (
    input logic                  clk,
    input logic                  reset,
    input scc_pkg::ipl_t         ipl,
    input scc_pkg::ipl_t         ack_level,
    input scc_pkg::uart_status_t uart_status,
    input logic                  uart_tx,
    input logic                  autovector,
    input logic                  in2,
    input logic                  in4,
    input logic                  in5,
    input logic                  irq_ack,
    input logic                  iack2,
    input logic                  iack4,
    input logic                  iack5,
    input logic                  t0_ov,
    input logic [15:0]           timer0,
    input logic [15:0]           reload
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;  // Read by the testbench at the end

    // First edge out of reset
    a_reset_state: assert property (@(posedge clk) $fell(reset) |->
        ipl == 3'd0 && !autovector && uart_tx && uart_status.tx_rdy && !uart_status.rx_rdy)
    else begin
        fail_count++;
        $error("outputs not in their reset state");
    end

    a_iack2: assert property (@(posedge clk) disable iff (reset)
        iack2 |-> in2 && irq_ack && ack_level == 3'd2)
    else begin
        fail_count++;
        $error("iack2 without in2, irq_ack and level 2");
    end

    a_iack4: assert property (@(posedge clk) disable iff (reset)
        iack4 |-> in4 && irq_ack && ack_level == 3'd4)
    else begin
        fail_count++;
        $error("iack4 without in4, irq_ack and level 4");
    end

    a_iack5: assert property (@(posedge clk) disable iff (reset)
        iack5 |-> in5 && irq_ack && ack_level == 3'd5)
    else begin
        fail_count++;
        $error("iack5 without in5, irq_ack and level 5");
    end

    // Overflow reloads and flags on the next edge
    a_overflow: assert property (@(posedge clk) disable iff (reset)
        timer0 == 16'hffff |=> t0_ov && timer0 == $past(reload))
    else begin
        fail_count++;
        $error("timer 0 overflow did not reload or set t0_ov");
    end

endmodule

bind scc_periph_top scc_sva u_sva (
    .clk (clk), .reset (reset), .ipl (ipl), .ack_level (ack_level),
    .uart_status (uart_status), .uart_tx (uart_tx), .autovector (autovector),
    .in2 (in2), .in4 (in4), .in5 (in5), .irq_ack (irq_ack),
    .iack2 (iack2), .iack4 (iack4), .iack5 (iack5),
    .t0_ov (t0_ov), .timer0 (timer0), .reload (reload)
);

// ==== tb/scc_tb.sv ====
/*
 * Testbench for the on-chip peripheral block.
 * Drives CPU bus, interrupt pins and serial line, checks the responses.
 */

`include "scc_config.svh"

module scc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS     = `SCC_UART_CLKS_PER_BIT;
    localparam int PRESCALE = `SCC_TIMER_PRESCALE;
    // Two serial frames, the overflow wait and slack for the register tests
    localparam int WATCHDOG_NS = (2 * 11 * CLKS + 2 * PRESCALE + 1000) * 10;

    localparam logic [15:1] LIR          = `SCC_LIR_ADDR;
    localparam logic [15:1] PICR1        = `SCC_PICR1_ADDR;
    localparam logic [15:1] UART_MODE    = `SCC_UART_BASE;
    localparam logic [15:1] UART_STATUS  = `SCC_UART_BASE + 15'd1;
    localparam logic [15:1] UART_THR     = `SCC_UART_BASE + 15'd4;
    localparam logic [15:1] UART_RHR     = `SCC_UART_BASE + 15'd5;
    localparam logic [15:1] TIMER_STATUS = `SCC_TIMER_BASE;
    localparam logic [15:1] TIMER_RELOAD = `SCC_TIMER_BASE + 15'd1;
    localparam logic [15:1] TIMER0       = `SCC_TIMER_BASE + 15'd2;
    localparam logic [15:1] TIMER1       = `SCC_TIMER_BASE + 15'd3;

    logic        clk, reset;
    logic        periph_sel, uds, lds, write_strobe;
    logic [15:1] addr;
    logic [15:0] wdata, rdata;
    logic        int1, int2, in2, in4, in5, av, irq_ack;
    logic [2:0]  ack_level, ipl;
    logic        autovector, iack2, iack4, iack5;
    logic        uart_rx, uart_tx;

    int          errors, test_start_errors, tests_passed, tests_failed;
    int unsigned sva_fails;
    logic [2:0]  timer_lvl;  // Shared by the overflow and vector tests

    scc_periph_top u_scc_periph_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a test is stuck", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // Bus tasks start right after a falling edge and end on one
    task automatic bus_release();
        periph_sel   = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
    endtask

    task automatic bus_write(input logic [15:1] a, input logic [15:0] d,
                             input logic hi, input logic lo);
        periph_sel   = 1'b1;
        addr         = a;
        wdata        = d;
        uds          = hi;
        lds          = lo;
        write_strobe = 1'b1;
        @(negedge clk);
        bus_release();
    endtask

    task automatic bus_read(input logic [15:1] a, output logic [15:0] d);
        periph_sel   = 1'b1;
        addr         = a;
        uds          = 1'b1;
        lds          = 1'b1;
        write_strobe = 1'b0;
        #2 d = rdata;  // Mid low phase
        @(negedge clk);
        bus_release();
    endtask

    // Poll one status bit, one read per cycle
    task automatic wait_bit(input logic [15:1] a, input int bit_idx, input int limit,
                            input string what);
        logic [15:0] st;
        int          n;
        n = 0;
        bus_read(a, st);
        while (!st[bit_idx] && n < limit) begin
            bus_read(a, st);
            n++;
        end
        if (!st[bit_idx]) begin
            errors++;
            $display("timed out after %0d cycles waiting for %s", limit, what);
        end
    endtask

    task automatic serial_send(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (CLKS) @(negedge clk);
        end
    endtask

    // src holds in2, in4, in5, int1, int2 from the top bit down
    function automatic logic [2:0] expected_level(input logic [4:0] src,
                                                  input logic [2:0] l1, input logic [2:0] l2);
        logic [2:0] lvl;
        lvl = 3'd0;
        if (src[4]) lvl = 3'd2;
        if (src[3]) lvl = 3'd4;
        if (src[2]) lvl = 3'd5;
        if (src[1] && l1 != 3'd0) lvl = l1;
        if (src[0] && l2 != 3'd0) lvl = l2;
        return lvl;
    endfunction

    function automatic logic expected_autovector(input logic [4:0] src, input logic av_in,
                                                 input logic [2:0] l1, input logic [2:0] l2,
                                                 input logic [2:0] lvl);
        logic flag;
        flag = 1'b1;
        if (lvl == 3'd4) flag = av_in;
        if (src[1] && l1 != 3'd0 && l1 == lvl) flag = 1'b0;  // Vector comes from chip
        if (src[0] && l2 != 3'd0 && l2 == lvl) flag = 1'b0;
        return flag;
    endfunction

    task automatic readback_test();
        logic [7:0]  d8, lir_byte;
        logic [15:0] d16, rd;
        d8 = 8'($urandom);
        bus_write(LIR, {8'h00, d8}, 1'b0, 1'b1);
        bus_read(LIR, rd);
        lir_byte = {1'b0, d8[6:4], 1'b0, d8[2:0]};
        check_value("rdata LIR", rd, {lir_byte, lir_byte});
        d8 = 8'($urandom);
        bus_write(PICR1, {8'h00, d8}, 1'b0, 1'b1);
        bus_read(PICR1, rd);
        check_value("rdata PICR1", rd, {5'b0, d8[2:0], 5'b0, d8[2:0]});
        d16 = 16'($urandom);
        bus_write(TIMER_RELOAD, d16, 1'b1, 1'b1);
        bus_read(TIMER_RELOAD, rd);
        check_value("rdata reload", rd, d16);
        bus_read(TIMER1, rd);
        check_value("rdata timer 1", rd, 16'h0000);
        bus_read(UART_MODE, rd);
        check_value("rdata UART mode", rd, 16'h0000);
        finish_test("register readback");
    endtask

    task automatic priority_test();
        logic [2:0] l1, l2;
        logic [4:0] src;
        logic       exp_av;
        l1 = 3'($urandom_range(7, 1));
        l2 = 3'($urandom_range(7, 1));
        bus_write(LIR, {8'h00, 1'b0, l1, 1'b0, l2}, 1'b0, 1'b1);
        for (int n = 0; n < 64; n++) begin
            src = 5'($urandom);
            {in2, in4, in5, int1, int2} = src;
            av        = 1'($urandom);
            irq_ack   = ($urandom % 4) != 0;  // Mostly acknowledging
            ack_level = 3'($urandom);
            #2;
            check_value("ipl", ipl, expected_level(src, l1, l2));
            check_value("iack2", iack2, in2 && irq_ack && ack_level == 3'd2);
            check_value("iack4", iack4, in4 && irq_ack && ack_level == 3'd4);
            check_value("iack5", iack5, in5 && irq_ack && ack_level == 3'd5);
            exp_av = expected_autovector(src, av, l1, l2, ack_level);
            @(negedge clk);
            check_value("autovector", autovector, exp_av);
        end
        {in2, in4, in5, int1, int2, av, irq_ack} = '0;
        ack_level = 3'd0;
        @(negedge clk);
        finish_test("priority and acknowledge");
    endtask

    task automatic timer_overflow_test();
        logic [15:0] r, rd;
        timer_lvl = 3'($urandom_range(7, 1));
        r         = {1'b0, 15'($urandom)};  // Far from the top
        bus_write(PICR1, {13'b0, timer_lvl}, 1'b0, 1'b1);
        bus_write(TIMER_RELOAD, r, 1'b1, 1'b1);
        bus_write(TIMER0, 16'hfffe, 1'b1, 1'b1);
        wait_bit(TIMER_STATUS, 15, PRESCALE + 2, "t0_ov");
        bus_read(TIMER0, rd);
        check_value("timer0", rd, r);
        check_value("ipl", ipl, timer_lvl);
        finish_test("timer overflow");
    endtask

    task automatic vector_clear_test();
        logic [15:0] rd;
        irq_ack   = 1'b1;
        ack_level = timer_lvl;
        bus_read(LIR, rd);  // Any address during acknowledge
        check_value("rdata vector", rd, 16'(`SCC_VECTOR_BASE) + 16'(timer_lvl));
        check_value("autovector", autovector, 1'b0);
        irq_ack   = 1'b0;
        ack_level = 3'd0;
        bus_write(TIMER_STATUS, 16'h8000, 1'b1, 1'b0);
        bus_read(TIMER_STATUS, rd);
        check_value("t0_ov", rd[15], 1'b0);
        check_value("ipl", ipl, 3'd0);
        finish_test("on-chip vector and clear");
    endtask

    task automatic uart_tx_test();
        logic [7:0]  b, got;
        logic [15:0] rd;
        int          n;
        b = 8'($urandom);
        bus_write(UART_THR, {8'h00, b}, 1'b0, 1'b1);
        bus_read(UART_STATUS, rd);
        check_value("tx_rdy", rd[2], 1'b0);
        n = 0;
        while (uart_tx && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (uart_tx) begin
            errors++;
            $display("transmitter never sent a start bit");
        end else begin
            repeat (CLKS / 2) @(negedge clk);  // Centre of the start bit
            check_value("uart_tx start", uart_tx, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge clk);
                got[i] = uart_tx;
            end
            check_value("uart_tx data", got, b);
            repeat (CLKS) @(negedge clk);
            check_value("uart_tx stop", uart_tx, 1'b1);
            wait_bit(UART_STATUS, 3, CLKS, "tx_emt");
        end
        finish_test("UART transmit");
    endtask

    task automatic uart_rx_test();
        logic [7:0]  b;
        logic [15:0] rd;
        b = 8'($urandom);
        serial_send(b);
        wait_bit(UART_STATUS, 0, CLKS, "rx_rdy");
        bus_read(UART_RHR, rd);
        check_value("rdata RHR", rd, {8'h00, b});
        bus_read(UART_STATUS, rd);
        check_value("rx_rdy", rd[0], 1'b0);
        finish_test("UART receive");
    endtask

    initial begin
        void'($urandom(32'hedc4_21c8));
        {errors, test_start_errors, tests_passed, tests_failed} = '0;
        reset = 1'b1;
        bus_release();
        addr  = '0;
        wdata = '0;
        {int1, int2, in2, in4, in5, av, irq_ack} = '0;
        ack_level = 3'd0;
        uart_rx   = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        readback_test();
        priority_test();
        timer_overflow_test();
        vector_clear_test();
        uart_tx_test();
        uart_rx_test();

        sva_fails = u_scc_periph_top.u_sva.fail_count;
        $display("%0d tests passed, %0d failed, %0d check errors, %0d assertion failures",
                 tests_passed, tests_failed, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
